/* verilog.f */
rtl/cgra_pkg.sv
rtl/cgra_reg_pipe.sv
rtl/cgra_memory.sv
rtl/cgra_alu.sv
rtl/cgra_program_counter.sv
rtl/cgra_conf_reader_pe.sv
rtl/cgra_pe.sv
rtl/cgra_array.sv
test/cgra_array_tb.sv

/* Makefile */
TOP = cgra_array_tb

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

/* test/cgra_array_tb.sv */
`timescale 1ns/1ps

module cgra_array_tb import cgra_pkg::*; ();

  localparam int NUM_PE       = 2;
  localparam int RESET_CYCLES = 8;
  localparam int HOLD         = 20;
  localparam int STALL        = 20;
  localparam int SLOT         = RESET_CYCLES + 20 + HOLD + 4;   // Reset, config, hold, checks.
  localparam int LIMIT        = 13 * SLOT + STALL + HOLD + 100;

  logic              clk;
  logic              reset;
  logic              en;
  conf_bus_t         conf;
  logic [DATA_W-1:0] ina;
  logic [DATA_W-1:0] inb;
  logic [DATA_W-1:0] outa;
  logic [DATA_W-1:0] outb;
  logic [15:0]       lfsr = 16'd41765;
  int                cycles = 0;
  int                checks = 0;
  int                errors = 0;

  cgra_array #(.NUM_PE(NUM_PE)) dut0 (
    .clk(clk), .reset(reset), .en(en), .conf(conf),
    .ina(ina), .inb(inb), .outa(outa), .outb(outb)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == LIMIT) begin
      $display("Timeout after %0d cycles, the run did not complete.", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers and reference model
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic next_random_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];   // x^16+x^14+x^13+x^11+1.
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [DATA_W-1:0] random_word();
    logic [DATA_W-1:0] w;
    w = '0;
    for (int i = 0; i < DATA_W; i++) begin
      w = {w[DATA_W-2:0], next_random_bit()};
    end
    return w;
  endfunction

  function automatic logic [DATA_W-1:0] alu_model(input alu_op_e op,
                                                  input logic [DATA_W-1:0] a,
                                                  input logic [DATA_W-1:0] b);
    logic [2*DATA_W-1:0] prod;
    prod = 32'(a) * 32'(b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_MUL:  return prod[DATA_W-1:0];
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SHL:  return a << b[3:0];
      OP_SHR:  return a >> b[3:0];
      default: return a;
    endcase
  endfunction

  function automatic inst_t make_inst(input alu_op_e op, input src_sel_e src_a,
                                      input src_sel_e src_b, input dst_sel_e dst,
                                      input int raddr, input int waddr);
    inst_t i;
    i.op       = op;
    i.src_a    = src_a;
    i.src_b    = src_b;
    i.dst      = dst;
    i.rf_raddr = RF_AW'(raddr);
    i.rf_waddr = RF_AW'(waddr);
    return i;
  endfunction

  function automatic conf_bus_t conf_word(input int pe, input conf_kind_e kind);
    conf_bus_t w;
    w         = '0;
    w.valid   = 1'b1;
    w.pe_id   = PE_ID_W'(pe);
    w.kind    = kind;
    return w;
  endfunction

  task automatic reset_dut();
    @(posedge clk);
    reset <= 1'b1;
    en    <= 1'b0;
    conf  <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic load_inst(input int pe, input int addr, input inst_t inst);
    conf_bus_t w;
    w = conf_word(pe, CONF_INST);
    w.payload.inst_wr.addr = INST_AW'(addr);
    w.payload.inst_wr.inst = inst;
    @(posedge clk);
    conf <= w;
  endtask

  task automatic load_const(input int pe, input int addr, input logic [DATA_W-1:0] value);
    conf_bus_t w;
    w = conf_word(pe, CONF_CONST);
    w.payload.const_wr.addr  = RF_AW'(addr);
    w.payload.const_wr.value = value;
    @(posedge clk);
    conf <= w;
  endtask

  task automatic load_loop(input int pe, input int pc_max, input int pc_loop);
    conf_bus_t w;
    w = conf_word(pe, CONF_LOOP);
    w.payload.loop_cfg.pc_max  = INST_AW'(pc_max);
    w.payload.loop_cfg.pc_loop = INST_AW'(pc_loop);
    @(posedge clk);
    conf <= w;
  endtask

  task automatic release_conf();
    @(posedge clk);
    conf <= '0;
    repeat (2) @(posedge clk);   // Strobe, then memory write.
  endtask

  task automatic program_pass(input int pe);
    load_inst(pe, 0, make_inst(OP_ADD, SRC_INA, SRC_ZERO, DST_OUTA, 0, 0));
    load_inst(pe, 1, make_inst(OP_ADD, SRC_INB, SRC_ZERO, DST_OUTB, 0, 0));
    load_loop(pe, 1, 0);
  endtask

  task automatic run_with(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
    @(posedge clk);
    ina <= a;
    inb <= b;
    en  <= 1'b1;
    repeat (HOLD) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
    checks++;
    assert (act === exp)
    else begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_outputs_zero();
    @(negedge clk);
    check_value("reset_outa", '0, outa);
    check_value("reset_outb", '0, outb);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic idle_after_reset();
    reset_dut();
    check_outputs_zero();
    program_pass(0);
    check_outputs_zero();   // Outputs hold while words load.
    program_pass(1);
    check_outputs_zero();
    release_conf();
    repeat (10) begin
      check_outputs_zero();
    end
  endtask

  task automatic pass_through();
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    reset_dut();
    program_pass(0);
    program_pass(1);
    load_inst(5, 0, make_inst(OP_MUL, SRC_INA, SRC_INA, DST_OUTA, 0, 0));
    load_loop(5, 7, 3);   // Foreign PE id is ignored.
    release_conf();
    a = random_word();
    b = random_word();
    run_with(a, b);
    check_value("pass_outa", a, outa);
    check_value("pass_outb", b, outb);
  endtask

  task automatic alu_operations();
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    alu_op_e           op;
    for (int i = 0; i < 8; i++) begin
      op = alu_op_e'(i[3:0]);
      reset_dut();
      load_inst(0, 0, make_inst(op, SRC_INA, SRC_INB, DST_OUTA, 0, 0));
      load_loop(0, 0, 0);
      program_pass(1);
      release_conf();
      a = random_word();
      b = random_word();
      run_with(a, b);
      check_value($sformatf("alu_op%0d", i), alu_model(op, a, b), outa);
    end
  endtask

  task automatic const_operand();
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] c;
    reset_dut();
    c = random_word();
    program_pass(0);
    load_const(1, 5, c);
    load_inst(1, 0, make_inst(OP_ADD, SRC_INA, SRC_RF, DST_OUTA, 5, 0));
    load_loop(1, 0, 0);
    release_conf();
    a = random_word();
    run_with(a, random_word());
    check_value("const_add", alu_model(OP_ADD, a, c), outa);
  endtask

  task automatic rf_writeback();
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    reset_dut();
    load_inst(0, 0, make_inst(OP_XOR, SRC_INA, SRC_INB, DST_RF, 0, 2));
    load_inst(0, 1, make_inst(OP_ADD, SRC_ZERO, SRC_ZERO, DST_NONE, 0, 0));
    load_inst(0, 2, make_inst(OP_ADD, SRC_ZERO, SRC_ZERO, DST_NONE, 0, 0));
    load_inst(0, 3, make_inst(OP_SUB, SRC_RF, SRC_INA, DST_OUTA, 2, 0));
    load_loop(0, 3, 0);
    program_pass(1);
    release_conf();
    a = random_word();
    b = random_word() & ~a;   // No common bits, so XOR acts as ADD.
    run_with(a, b);
    check_value("rf_writeback", b, outa);
  endtask

  task automatic stall_freeze();
    logic [DATA_W-1:0] a1;
    logic [DATA_W-1:0] b1;
    logic [DATA_W-1:0] a2;
    logic [DATA_W-1:0] b2;
    reset_dut();
    program_pass(0);
    program_pass(1);
    release_conf();
    a1 = random_word();
    b1 = random_word();
    a2 = ~a1;
    b2 = ~b1;
    run_with(a1, b1);
    check_value("stall_before_a", a1, outa);
    check_value("stall_before_b", b1, outb);
    @(posedge clk);
    en <= 1'b0;
    @(posedge clk);
    ina <= a2;
    inb <= b2;
    repeat (STALL) begin
      @(negedge clk);
      check_value("stall_hold_a", a1, outa);
      check_value("stall_hold_b", b1, outb);
    end
    run_with(a2, b2);
    check_value("stall_after_a", a2, outa);
    check_value("stall_after_b", b2, outb);
  endtask

  initial begin
    reset = 1'b1;
    en    = 1'b0;
    conf  = '0;
    ina   = '0;
    inb   = '0;
    idle_after_reset();
    pass_through();
    alu_operations();
    const_operand();
    rf_writeback();
    stall_freeze();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* rtl/cgra_array.sv */
`timescale 1ns/1ps

module cgra_array import cgra_pkg::*; #(
  parameter int NUM_PE = 2
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              en,
  input  conf_bus_t         conf,
  input  logic [DATA_W-1:0] ina,
  input  logic [DATA_W-1:0] inb,
  output logic [DATA_W-1:0] outa,
  output logic [DATA_W-1:0] outb
);

  logic [DATA_W-1:0] chain_a [NUM_PE+1];
  logic [DATA_W-1:0] chain_b [NUM_PE+1];

  assign chain_a[0] = ina;
  assign chain_b[0] = inb;

  for (genvar k = 0; k < NUM_PE; k++) begin : g_pe
    cgra_pe #(.PE_ID(k)) u_pe (
      .clk(clk), .reset(reset), .en(en), .conf(conf),
      .ina(chain_a[k]), .inb(chain_b[k]),
      .outa(chain_a[k+1]), .outb(chain_b[k+1])   // Feeds the next PE.
    );
  end

  assign outa = chain_a[NUM_PE];
  assign outb = chain_b[NUM_PE];

endmodule

/* rtl/cgra_pe.sv */
`timescale 1ns/1ps

module cgra_pe import cgra_pkg::*; #(
  parameter int PE_ID = 0
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              en,
  input  conf_bus_t         conf,
  input  logic [DATA_W-1:0] ina,
  input  logic [DATA_W-1:0] inb,
  output logic [DATA_W-1:0] outa,
  output logic [DATA_W-1:0] outb
);

  typedef struct packed {
    alu_op_e  op;
    src_sel_e src_a;
    src_sel_e src_b;
  } dec_t;

  typedef struct packed {
    dst_sel_e         dst;
    logic [RF_AW-1:0] waddr;
  } wb_t;

  logic               conf_wr_en;
  logic [INST_AW-1:0] conf_wr_addr;
  inst_t              conf_wr_data;
  logic               init_const_we;
  logic [RF_AW-1:0]   init_const_waddr;
  logic [DATA_W-1:0]  init_const;
  logic [INST_AW-1:0] pc_max;
  logic [INST_AW-1:0] pc_loop;
  logic [INST_AW-1:0] pc;
  logic               pc_en;
  inst_t              inst;
  dec_t               dec_d;
  dec_t               dec_q;
  wb_t                wb_d;
  wb_t                wb_q;
  logic [DATA_W-1:0]  ina_q;
  logic [DATA_W-1:0]  inb_q;
  logic [DATA_W-1:0]  rf_rdata;
  logic [DATA_W-1:0]  alu_a;
  logic [DATA_W-1:0]  alu_b;
  logic [DATA_W-1:0]  alu_out;
  logic               rf_re;
  logic               rf_we;
  logic [RF_AW-1:0]   rf_waddr;
  logic [DATA_W-1:0]  rf_wdata;
  logic               out_a_we;
  logic               out_b_we;
  logic               wb_rf_we;

  function automatic logic [DATA_W-1:0] pick(input src_sel_e sel, input logic [DATA_W-1:0] a,
                                             input logic [DATA_W-1:0] b,
                                             input logic [DATA_W-1:0] r);
    case (sel)
      SRC_INA: return a;
      SRC_INB: return b;
      SRC_RF:  return r;
      default: return '0;
    endcase
  endfunction

  cgra_conf_reader_pe #(.PE_ID(PE_ID)) u_conf (
    .clk(clk), .reset(reset), .conf(conf),
    .conf_wr_en(conf_wr_en), .conf_wr_addr(conf_wr_addr), .conf_wr_data(conf_wr_data),
    .init_const_we(init_const_we), .init_const_waddr(init_const_waddr),
    .init_const(init_const), .pc_max(pc_max), .pc_loop(pc_loop)
  );

  cgra_program_counter u_pc (
    .clk(clk), .reset(reset), .en(en), .max(pc_max), .loop(pc_loop),
    .pc(pc), .pc_en(pc_en)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Fetch and decode
  ////////////////////////////////////////////////////////////////////////////
  cgra_memory #(.DATA_WIDTH(DATA_W), .ADDR_WIDTH(INST_AW)) u_inst_mem (
    .clk(clk), .we(conf_wr_en), .re(pc_en), .raddr(pc), .waddr(conf_wr_addr),
    .din(conf_wr_data), .dout(inst)
  );

  assign dec_d = '{op: inst.op, src_a: inst.src_a, src_b: inst.src_b};
  assign wb_d  = '{dst: inst.dst, waddr: inst.rf_waddr};
  assign rf_re = en && ((inst.src_a == SRC_RF) || (inst.src_b == SRC_RF));

  cgra_reg_pipe #(.NUM_STAGES(1), .DATA_WIDTH($bits(dec_t))) u_dec_pipe (
    .clk(clk), .reset(reset), .en(en), .in(dec_d), .out(dec_q)
  );

  cgra_reg_pipe #(.NUM_STAGES(2), .DATA_WIDTH($bits(wb_t))) u_wb_pipe (
    .clk(clk), .reset(reset), .en(en), .in(wb_d), .out(wb_q)   // Decode to write-back.
  );

  cgra_reg_pipe #(.NUM_STAGES(1), .DATA_WIDTH(DATA_W)) u_ina_pipe (
    .clk(clk), .reset(reset), .en(en), .in(ina), .out(ina_q)
  );

  cgra_reg_pipe #(.NUM_STAGES(1), .DATA_WIDTH(DATA_W)) u_inb_pipe (
    .clk(clk), .reset(reset), .en(en), .in(inb), .out(inb_q)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Operands, ALU and write-back
  ////////////////////////////////////////////////////////////////////////////
  assign alu_a = pick(dec_q.src_a, ina_q, inb_q, rf_rdata);
  assign alu_b = pick(dec_q.src_b, ina_q, inb_q, rf_rdata);

  cgra_alu #(.DATA_WIDTH(DATA_W)) u_alu (
    .clk(clk), .reset(reset), .en(en), .op(dec_q.op), .ina(alu_a), .inb(alu_b),
    .out(alu_out)
  );

  assign out_a_we = en && (wb_q.dst == DST_OUTA);
  assign out_b_we = en && (wb_q.dst == DST_OUTB);
  assign wb_rf_we = en && (wb_q.dst == DST_RF);

  // Configuration constant wins over the ALU result.
  assign rf_we    = init_const_we || wb_rf_we;
  assign rf_waddr = init_const_we ? init_const_waddr : wb_q.waddr;
  assign rf_wdata = init_const_we ? init_const : alu_out;

  cgra_memory #(.DATA_WIDTH(DATA_W), .ADDR_WIDTH(RF_AW)) u_rf (
    .clk(clk), .we(rf_we), .re(rf_re), .raddr(inst.rf_raddr), .waddr(rf_waddr),
    .din(rf_wdata), .dout(rf_rdata)
  );

  cgra_reg_pipe #(.NUM_STAGES(1), .DATA_WIDTH(DATA_W)) u_outa_reg (
    .clk(clk), .reset(reset), .en(out_a_we), .in(alu_out), .out(outa)
  );

  cgra_reg_pipe #(.NUM_STAGES(1), .DATA_WIDTH(DATA_W)) u_outb_reg (
    .clk(clk), .reset(reset), .en(out_b_we), .in(alu_out), .out(outb)
  );

endmodule

/* rtl/cgra_conf_reader_pe.sv */
`timescale 1ns/1ps

module cgra_conf_reader_pe import cgra_pkg::*; #(
  parameter int PE_ID = 0
) (
  input  logic               clk,
  input  logic               reset,
  input  conf_bus_t          conf,
  output logic               conf_wr_en,
  output logic [INST_AW-1:0] conf_wr_addr,
  output inst_t              conf_wr_data,
  output logic               init_const_we,
  output logic [RF_AW-1:0]   init_const_waddr,
  output logic [DATA_W-1:0]  init_const,
  output logic [INST_AW-1:0] pc_max,
  output logic [INST_AW-1:0] pc_loop
);

  logic hit;

  assign hit = conf.valid && (conf.pe_id == PE_ID_W'(PE_ID));

  always_ff @(posedge clk) begin
    if (reset) begin
      conf_wr_en    <= 1'b0;
      init_const_we <= 1'b0;
      pc_max        <= '0;
      pc_loop       <= '0;
    end else begin
      conf_wr_en    <= hit && (conf.kind == CONF_INST);
      init_const_we <= hit && (conf.kind == CONF_CONST);
      if (hit && (conf.kind == CONF_LOOP)) begin
        pc_max  <= conf.payload.loop_cfg.pc_max;
        pc_loop <= conf.payload.loop_cfg.pc_loop;
      end
    end
  end

  // Payload fields are qualified by the strobes above.
  always_ff @(posedge clk) begin
    conf_wr_addr     <= conf.payload.inst_wr.addr;
    conf_wr_data     <= conf.payload.inst_wr.inst;
    init_const_waddr <= conf.payload.const_wr.addr;
    init_const       <= conf.payload.const_wr.value;
  end

endmodule

/* rtl/cgra_program_counter.sv */
`timescale 1ns/1ps

module cgra_program_counter import cgra_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               en,
  input  logic [INST_AW-1:0] max,
  input  logic [INST_AW-1:0] loop,
  output logic [INST_AW-1:0] pc,
  output logic               pc_en
);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (en) begin
      if (pc == max) begin
        pc <= loop;   // Wrap to loop start.
      end else begin
        pc <= pc + 1'b1;
      end
    end
  end

  // Instruction fetch follows the global enable.
  assign pc_en = en;

endmodule

/* rtl/cgra_alu.sv */
`timescale 1ns/1ps

module cgra_alu import cgra_pkg::*; #(
  parameter int DATA_WIDTH = 16
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  en,
  input  alu_op_e               op,
  input  logic [DATA_WIDTH-1:0] ina,
  input  logic [DATA_WIDTH-1:0] inb,
  output logic [DATA_WIDTH-1:0] out
);

  localparam int SH_W = $clog2(DATA_WIDTH);

  logic [2*DATA_WIDTH-1:0] product;
  logic [DATA_WIDTH-1:0]   result;

  assign product = ina * inb;

  always_comb begin
    case (op)
      OP_ADD:  result = ina + inb;
      OP_SUB:  result = ina - inb;
      OP_MUL:  result = product[DATA_WIDTH-1:0];   // Low half only.
      OP_AND:  result = ina & inb;
      OP_OR:   result = ina | inb;
      OP_XOR:  result = ina ^ inb;
      OP_SHL:  result = ina << inb[SH_W-1:0];
      OP_SHR:  result = ina >> inb[SH_W-1:0];
      default: result = ina;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out <= '0;
    end else if (en) begin
      out <= result;
    end
  end

endmodule

/* rtl/cgra_memory.sv */
`timescale 1ns/1ps

module cgra_memory #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  we,
  input  logic                  re,
  input  logic [ADDR_WIDTH-1:0] raddr,
  input  logic [ADDR_WIDTH-1:0] waddr,
  input  logic [DATA_WIDTH-1:0] din,
  output logic [DATA_WIDTH-1:0] dout
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= din;
    end
    if (re) begin
      dout <= mem[raddr];   // Old data on a same-address write.
    end
  end

endmodule

/* rtl/cgra_reg_pipe.sv */
`timescale 1ns/1ps

module cgra_reg_pipe #(
  parameter int NUM_STAGES = 1,
  parameter int DATA_WIDTH = 16
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  en,
  input  logic [DATA_WIDTH-1:0] in,
  output logic [DATA_WIDTH-1:0] out
);

  logic [DATA_WIDTH-1:0] stage [NUM_STAGES];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_STAGES; i++) begin
        stage[i] <= '0;
      end
    end else if (en) begin
      stage[0] <= in;
      for (int i = 1; i < NUM_STAGES; i++) begin
        stage[i] <= stage[i-1];   // Shift toward the output.
      end
    end
  end

  assign out = stage[NUM_STAGES-1];

endmodule

/* rtl/cgra_pkg.sv */
package cgra_pkg;

  localparam int DATA_W  = 16;
  localparam int INST_AW = 8;
  localparam int RF_AW   = 3;
  localparam int PE_ID_W = 8;

  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_MUL = 4'd2,
    OP_AND = 4'd3,
    OP_OR  = 4'd4,
    OP_XOR = 4'd5,
    OP_SHL = 4'd6,
    OP_SHR = 4'd7
  } alu_op_e;

  typedef enum logic [1:0] {SRC_INA, SRC_INB, SRC_RF, SRC_ZERO} src_sel_e;

  typedef enum logic [1:0] {DST_OUTA, DST_OUTB, DST_RF, DST_NONE} dst_sel_e;

  typedef struct packed {
    alu_op_e              op;
    src_sel_e             src_a;
    src_sel_e             src_b;
    dst_sel_e             dst;
    logic [RF_AW-1:0]     rf_raddr;
    logic [RF_AW-1:0]     rf_waddr;
  } inst_t;

  typedef enum logic [1:0] {CONF_INST, CONF_CONST, CONF_LOOP} conf_kind_e;

  //////////////////////////////////////////////////////////////////////////
  // One 49-bit configuration payload read three ways.
  //////////////////////////////////////////////////////////////////////////
  typedef union packed {
    struct packed {
      logic [24:0]          pad;
      logic [INST_AW-1:0]   addr;
      inst_t                inst;
    } inst_wr;
    struct packed {
      logic [29:0]          pad;
      logic [RF_AW-1:0]     addr;
      logic [DATA_W-1:0]    value;
    } const_wr;
    struct packed {
      logic [32:0]          pad;
      logic [INST_AW-1:0]   pc_max;
      logic [INST_AW-1:0]   pc_loop;
    } loop_cfg;
  } conf_payload_u;

  typedef struct packed {
    logic                 valid;
    logic [PE_ID_W-1:0]   pe_id;
    conf_kind_e           kind;
    conf_payload_u        payload;
  } conf_bus_t;

endpackage
